// File: hw/block_mover.sv
`timescale 1ns/100ps
`default_nettype none

module block_mover
    import wb_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  logic      start,
    input  logic      single,
    input  logic      we,
    input  word_t     base_adr,
    input  line_t     wr_line,
    input  sel_t      single_sel,
    input  word_t     single_wdata,
    output logic      fill_valid,
    output word_idx_t fill_idx,
    output word_t     fill_word,
    output logic      done,
    output logic      mem_cyc,
    output logic      mem_stb,
    output logic      mem_we,
    output word_t     mem_adr,
    output sel_t      mem_sel,
    output word_t     mem_dat_w,
    input  logic      mem_ack,
    input  word_t     mem_dat_r
);

    enum logic [1:0] {
        MV_IDLE,
        MV_REQ,
        MV_GAP,
        MV_DONE
    } state;

    word_idx_t   cnt;
    cache_addr_u word_adr;
    logic        last_word;

    assign last_word = single || (cnt == word_idx_t'(BLOCK_WORDS - 1));

    // word address inside the line, byte offset dropped
    always_comb begin
        word_adr = cache_addr_u'(base_adr);
        word_adr.f.word = cnt;
        word_adr.f.byte_off = '0;
    end

    // cyc stays up between the words of a line
    assign mem_cyc = (state == MV_REQ) || (state == MV_GAP);
    assign mem_stb = state == MV_REQ;
    assign mem_we = we;
    assign mem_adr = single ? base_adr : word_adr.raw;
    assign mem_sel = single ? single_sel : '1;
    assign mem_dat_w = single ? single_wdata : wr_line[cnt];

    assign fill_valid = mem_stb && mem_ack && !we;
    assign fill_idx = cnt;
    assign fill_word = mem_dat_r;
    assign done = state == MV_DONE;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= MV_IDLE;
            cnt <= '0;
        end else begin
            case (state)
                MV_IDLE: begin
                    if (start) begin
                        cnt <= '0;
                        state <= MV_REQ;
                    end
                end
                MV_REQ: begin
                    if (mem_ack) begin
                        if (last_word) begin
                            state <= MV_DONE;
                        end else begin
                            cnt <= cnt + 1'b1;
                            state <= MV_GAP;
                        end
                    end
                end
                // one idle cycle before the next strobe
                MV_GAP: begin
                    state <= MV_REQ;
                end
                MV_DONE: begin
                    state <= MV_IDLE;
                end
                default: begin
                    state <= MV_IDLE;
                end
            endcase
        end
    end

    // a stalled transfer keeps the bus still until memory answers
    hold_while_waiting: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_stb && !mem_ack) |=> mem_stb && $stable(mem_adr) && $stable(mem_we)
            && $stable(mem_dat_w));

endmodule

`default_nettype wire

// File: hw/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl
    import wb_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  logic      flush,
    output logic      flush_done,
    input  logic      cpu_cyc,
    input  logic      cpu_stb,
    input  logic      cpu_we,
    input  word_t     cpu_adr,
    input  sel_t      cpu_sel,
    input  word_t     cpu_dat_w,
    output logic      cpu_ack,
    output word_t     cpu_dat_r,
    output count_t    misses,
    output set_idx_t  rd_set,
    input  logic      rd_valid,
    input  logic      rd_dirty,
    input  tag_t      rd_tag,
    input  line_t     rd_line,
    output logic      meta_we,
    output logic      wr_valid,
    output logic      wr_dirty,
    output tag_t      wr_tag,
    output logic      word_we,
    output word_idx_t wr_word_idx,
    output sel_t      wr_sel,
    output word_t     wr_word,
    output logic      mv_start,
    output logic      mv_single,
    output logic      mv_we,
    output word_t     mv_base,
    output line_t     mv_line,
    output sel_t      mv_sel,
    output word_t     mv_wdata,
    input  logic      fill_valid,
    input  word_idx_t fill_idx,
    input  word_t     fill_word,
    input  logic      mv_done
);

    enum logic [2:0] {
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_FETCH,
        ST_BYPASS,
        ST_FLUSH_SCAN,
        ST_FLUSH_WRITE
    } state;

    cache_addr_u req;
    cache_addr_u line_base;
    set_idx_t    scan_set;
    logic        flush_req;
    logic        flush_pend;
    logic        ack_byp;
    word_t       byp_data;
    logic        cacheable;
    logic        hit;
    logic        victim_dirty;
    logic        last_set;

    assign req = cache_addr_u'(cpu_adr);
    assign cacheable = cpu_adr < NONCACHE_BASE;
    assign hit = rd_valid && (rd_tag == req.f.tag);
    assign victim_dirty = rd_valid && rd_dirty;
    assign flush_pend = flush || flush_req;
    assign last_set = scan_set == set_idx_t'(N_SETS - 1);

    // flush walks the sets and everything else indexes by the request
    assign rd_set = (state == ST_FLUSH_SCAN || state == ST_FLUSH_WRITE) ? scan_set : req.f.set;

    // first word address of the line being moved
    always_comb begin
        line_base = '0;
        line_base.f.set = rd_set;
        line_base.f.tag = (state == ST_FETCH) ? req.f.tag : rd_tag;
    end

    assign mv_start = state inside {ST_WRITEBACK, ST_FETCH, ST_BYPASS, ST_FLUSH_WRITE};
    assign mv_single = state == ST_BYPASS;
    assign mv_we = (state == ST_BYPASS) ? cpu_we
                 : (state == ST_WRITEBACK || state == ST_FLUSH_WRITE);
    assign mv_base = mv_single ? cpu_adr : line_base.raw;
    assign mv_line = rd_line;
    assign mv_sel = cpu_sel;
    assign mv_wdata = cpu_dat_w;

    // hit data comes straight from the line during the ack cycle
    assign cpu_dat_r = ack_byp ? byp_data : rd_line[req.f.word];

    always_comb begin
        meta_we = 1'b0;
        wr_valid = 1'b0;
        wr_dirty = 1'b0;
        wr_tag = req.f.tag;
        word_we = 1'b0;
        wr_word_idx = req.f.word;
        wr_sel = cpu_sel;
        wr_word = cpu_dat_w;
        flush_done = 1'b0;
        case (state)
            ST_LOOKUP: begin
                // write hit lands in the ack cycle
                if (cpu_ack && !ack_byp && cpu_we) begin
                    meta_we = 1'b1;
                    wr_valid = 1'b1;
                    wr_dirty = 1'b1;
                    word_we = 1'b1;
                end
            end
            ST_FETCH: begin
                word_we = fill_valid;
                wr_word_idx = fill_idx;
                wr_sel = '1;
                wr_word = fill_word;
                // tag and valid once the whole line is in
                meta_we = mv_done;
                wr_valid = 1'b1;
            end
            ST_FLUSH_SCAN: begin
                if (!victim_dirty) begin
                    meta_we = 1'b1;
                    flush_done = last_set;
                end
            end
            ST_FLUSH_WRITE: begin
                meta_we = mv_done;
                flush_done = mv_done && last_set;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= ST_LOOKUP;
            scan_set <= '0;
            flush_req <= 1'b0;
            cpu_ack <= 1'b0;
            ack_byp <= 1'b0;
            misses <= '0;
        end else begin
            cpu_ack <= 1'b0;
            ack_byp <= 1'b0;
            if (flush) begin
                flush_req <= 1'b1;
            end
            case (state)
                ST_LOOKUP: begin
                    // nothing new starts while an ack is out
                    if (!cpu_ack) begin
                        // a pending flush waits until the cpu access is acked
                        if (cpu_cyc && cpu_stb) begin
                            if (!cacheable) begin
                                state <= ST_BYPASS;
                            end else if (hit) begin
                                cpu_ack <= 1'b1;
                            end else begin
                                misses <= misses + 1'b1;
                                if (victim_dirty) begin
                                    state <= ST_WRITEBACK;
                                end else begin
                                    state <= ST_FETCH;
                                end
                            end
                        end else if (flush_pend) begin
                            flush_req <= 1'b0;
                            scan_set <= '0;
                            state <= ST_FLUSH_SCAN;
                        end
                    end
                end
                ST_WRITEBACK: begin
                    if (mv_done) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    // return to lookup where the request now hits
                    if (mv_done) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_BYPASS: begin
                    if (mv_done) begin
                        cpu_ack <= 1'b1;
                        ack_byp <= 1'b1;
                        state <= ST_LOOKUP;
                    end
                end
                ST_FLUSH_SCAN: begin
                    if (victim_dirty) begin
                        state <= ST_FLUSH_WRITE;
                    end else if (last_set) begin
                        state <= ST_LOOKUP;
                    end else begin
                        scan_set <= scan_set + 1'b1;
                    end
                end
                ST_FLUSH_WRITE: begin
                    if (mv_done) begin
                        if (last_set) begin
                            state <= ST_LOOKUP;
                        end else begin
                            scan_set <= scan_set + 1'b1;
                            state <= ST_FLUSH_SCAN;
                        end
                    end
                end
                default: begin
                    state <= ST_LOOKUP;
                end
            endcase
        end
    end

    // read data of an uncached access
    always_ff @(posedge CLK) begin
        if (state == ST_BYPASS && fill_valid) begin
            byp_data <= fill_word;
        end
    end

    // the cpu still holds its strobe while we acknowledge
    ack_needs_stb: assert property (@(posedge CLK) disable iff (!nRST)
        cpu_ack |-> cpu_stb);

    // completion comes only from the scan and lookup resumes next
    flush_done_in_scan: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |-> (state inside {ST_FLUSH_SCAN, ST_FLUSH_WRITE}) ##1 (state == ST_LOOKUP));

endmodule

`default_nettype wire

// File: hw/cache_geom_pkg.sv
`default_nettype none

// geometry of the direct-mapped data cache
package cache_geom_pkg;

    import wb_bus_pkg::*;

    // both must be powers of two, at least two words per line
    localparam int BLOCK_WORDS = 2;
    localparam int N_SETS = 64;

    localparam int BYTE_BITS = 2;
    localparam int WORD_BITS = $clog2(BLOCK_WORDS);
    localparam int SET_BITS = $clog2(N_SETS);
    localparam int TAG_BITS = $bits(word_t) - SET_BITS - WORD_BITS - BYTE_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic [WORD_BITS-1:0] word_idx_t;

    // word 0 sits in the low bits
    typedef word_t [BLOCK_WORDS-1:0] line_t;

    // same bus word seen raw or split into cache fields
    typedef union packed {
        word_t raw;
        struct packed {
            tag_t tag;
            set_idx_t set;
            word_idx_t word;
            logic [BYTE_BITS-1:0] byte_off;
        } f;
    } cache_addr_u;

    typedef logic [31:0] count_t;

endpackage

`default_nettype wire

// File: hw/l1_cache.sv
`timescale 1ns/100ps
`default_nettype none

module l1_cache
    import wb_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  logic   CLK,
    input  logic   nRST,
    input  logic   flush,
    output logic   flush_done,
    input  logic   cpu_cyc,
    input  logic   cpu_stb,
    input  logic   cpu_we,
    input  word_t  cpu_adr,
    input  sel_t   cpu_sel,
    input  word_t  cpu_dat_w,
    output logic   cpu_ack,
    output word_t  cpu_dat_r,
    output logic   mem_cyc,
    output logic   mem_stb,
    output logic   mem_we,
    output word_t  mem_adr,
    output sel_t   mem_sel,
    output word_t  mem_dat_w,
    input  logic   mem_ack,
    input  word_t  mem_dat_r,
    output count_t misses
);

    // line store read side and write strobes
    set_idx_t  rd_set;
    logic      rd_valid;
    logic      rd_dirty;
    tag_t      rd_tag;
    line_t     rd_line;
    logic      meta_we;
    logic      wr_valid;
    logic      wr_dirty;
    tag_t      wr_tag;
    logic      word_we;
    word_idx_t wr_word_idx;
    sel_t      wr_sel;
    word_t     wr_word;

    // controller requests to the memory-side master
    logic      mv_start;
    logic      mv_single;
    logic      mv_we;
    word_t     mv_base;
    line_t     mv_line;
    sel_t      mv_sel;
    word_t     mv_wdata;
    logic      fill_valid;
    word_idx_t fill_idx;
    word_t     fill_word;
    logic      mv_done;

    cache_ctrl cache_ctrl_inst (.*);

    line_store line_store_inst (.*);

    block_mover block_mover_inst (
        .start        (mv_start),
        .single       (mv_single),
        .we           (mv_we),
        .base_adr     (mv_base),
        .wr_line      (mv_line),
        .single_sel   (mv_sel),
        .single_wdata (mv_wdata),
        .done         (mv_done),
        .*
    );

endmodule

`default_nettype wire

// File: hw/line_store.sv
`timescale 1ns/100ps
`default_nettype none

module line_store
    import wb_bus_pkg::*;
    import cache_geom_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  set_idx_t  rd_set,
    output logic      rd_valid,
    output logic      rd_dirty,
    output tag_t      rd_tag,
    output line_t     rd_line,
    input  logic      meta_we,
    input  logic      wr_valid,
    input  logic      wr_dirty,
    input  tag_t      wr_tag,
    input  logic      word_we,
    input  word_idx_t wr_word_idx,
    input  sel_t      wr_sel,
    input  word_t     wr_word
);

    logic [N_SETS-1:0] valid_bits;
    logic [N_SETS-1:0] dirty_bits;
    tag_t              tag_mem [N_SETS];
    line_t             data_mem [N_SETS];

    // asynchronous read at the current set
    assign rd_valid = valid_bits[rd_set];
    assign rd_dirty = dirty_bits[rd_set];
    assign rd_tag = tag_mem[rd_set];
    assign rd_line = data_mem[rd_set];

    // state bits, the whole cache comes up invalid
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (meta_we) begin
            valid_bits[rd_set] <= wr_valid;
            dirty_bits[rd_set] <= wr_dirty;
        end
    end

    always_ff @(posedge CLK) begin
        if (meta_we) begin
            tag_mem[rd_set] <= wr_tag;
        end
        if (word_we) begin
            // only the selected byte lanes change
            for (int b = 0; b < $bits(sel_t); b++) begin
                if (wr_sel[b]) begin
                    data_mem[rd_set][wr_word_idx][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
    end

    // data written together with metadata must leave the line valid
    no_write_into_invalid: assert property (@(posedge CLK) disable iff (!nRST)
        (meta_we && word_we) |-> wr_valid);

endmodule

`default_nettype wire

// File: hw/wb_bus_pkg.sv
`default_nettype none

// wishbone bus word, byte select and the uncached region
package wb_bus_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // one select bit per byte lane
    typedef logic [WORD_W/8-1:0] sel_t;

    // everything from here up bypasses the cache
    localparam word_t NONCACHE_BASE = 32'hF000_0000;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the l1 cache testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_l1_cache -o tb_l1_cache_sim \
    && { sim_out="$(./obj_dir/tb_l1_cache_sim 2>&1)"; printf '%s\n' "$sim_out"; } \
    && printf '%s\n' "$sim_out" | grep -q "ALL CHECKS PASSED" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

// File: tb.f
+incdir+verif
hw/wb_bus_pkg.sv
hw/cache_geom_pkg.sv
hw/line_store.sv
hw/block_mover.sv
hw/cache_ctrl.sv
hw/l1_cache.sv
verif/tb_l1_cache.sv

// File: verif/cache_vectors.txt
# name op address select write_data expected_read_data expected_misses
# every field is hex except the decimal miss count and unused fields hold zero
rd_cold          read  00000100 f 00000000 fffffeff 1
rd_hit_w1        read  00000104 f 00000000 fffffefb 1
rd_hit_w0        read  00000100 f 00000000 fffffeff 1
wr_merge         write 00000104 5 11223344 00000000 1
rd_merged        read  00000104 f 00000000 ff22fe44 1
rd_evict         read  00000300 f 00000000 fffffcff 2
rd_refetch       read  00000104 f 00000000 ff22fe44 3
rd_refetch_w0    read  00000100 f 00000000 fffffeff 3
wr_bypass        write f0000010 f cafef00d 00000000 3
rd_bypass        read  f0000010 f 00000000 cafef00d 3
wr_bypass_part   write f0000010 3 0000beef 00000000 3
rd_bypass_part   read  f0000010 f 00000000 cafebeef 3
rd_bypass_init   read  f0000020 f 00000000 0fffffdf 3
wr_set0          write 00000200 f a5a50001 00000000 4
wr_set32         write 00000104 f 5a5a0002 00000000 4
wr_set63         write 000001fc c 77000000 00000000 5
flush_all        flush 00000000 0 00000000 00000000 5
rd_set0          read  00000200 f 00000000 a5a50001 6
rd_set32         read  00000104 f 00000000 5a5a0002 7
rd_set63         read  000001fc f 00000000 7700fe03 8
rd_set63_w0      read  000001f8 f 00000000 fffffe07 8
rd_set32_w0      read  00000100 f 00000000 fffffeff 8
rd_set0_w1       read  00000204 f 00000000 fffffdfb 8

// File: verif/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// compare a bus word against its expected value
task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        stop_with_failure();
    end
endtask

// miss counts and cycle counts
task automatic check_count(input string name, input count_t expected, input count_t actual);
    if (actual !== expected) begin
        $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
        stop_with_failure();
    end
endtask

// returns the number of cycles until cpu_ack shows up
task automatic wait_ack(input string name, output int cycles);
    int n;
    n = 0;
    do begin
        @(posedge CLK);
        #1;
        n++;
    end while (!cpu_ack && n < ACK_LIMIT);
    if (!cpu_ack) begin
        $display("%s: no acknowledge within limit", name);
        stop_with_failure();
    end
    cycles = n;
endtask

task automatic wait_flush_done(input string name);
    int n;
    n = 0;
    while (!flush_done && n < FLUSH_LIMIT) begin
        @(posedge CLK);
        #1;
        n++;
    end
    if (!flush_done) begin
        $display("%s: no flush completion within limit", name);
        stop_with_failure();
    end
endtask

`endif

// File: verif/tb_l1_cache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_l1_cache
    import wb_bus_pkg::*;
    import cache_geom_pkg::*;
();

    localparam int ACK_LIMIT = 200;
    localparam int FLUSH_LIMIT = 4000;
    localparam VECTOR_FILE = "verif/cache_vectors.txt";

    logic   CLK;
    logic   nRST;
    logic   flush;
    logic   flush_done;
    logic   cpu_cyc;
    logic   cpu_stb;
    logic   cpu_we;
    word_t  cpu_adr;
    sel_t   cpu_sel;
    word_t  cpu_dat_w;
    logic   cpu_ack;
    word_t  cpu_dat_r;
    logic   mem_cyc;
    logic   mem_stb;
    logic   mem_we;
    word_t  mem_adr;
    sel_t   mem_sel;
    word_t  mem_dat_w;
    logic   mem_ack;
    word_t  mem_dat_r;
    count_t misses;

    // sparse memory, only written words are stored
    word_t mem_words [word_t];
    int    seed;
    int    wait_left;
    logic  in_wait;

    l1_cache l1_cache_inst (.*);

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first failure");
    endtask

    `include "tb_checks.svh"

    function automatic word_t mem_read(input word_t adr);
        word_t key;
        key = {adr[31:2], 2'b00};
        if (mem_words.exists(key)) begin
            return mem_words[key];
        end
        // untouched words hold their inverted address
        return ~key;
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input sel_t sel);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // wishbone slave, 0 to 3 wait cycles per word
    always @(posedge CLK) begin
        #1;
        if (mem_ack) begin
            mem_ack = 1'b0;
        end else if (mem_cyc && mem_stb) begin
            if (!in_wait) begin
                in_wait = 1'b1;
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                in_wait = 1'b0;
                if (mem_we) begin
                    mem_words[{mem_adr[31:2], 2'b00}] =
                        merge_bytes(mem_read(mem_adr), mem_dat_w, mem_sel);
                end else begin
                    mem_dat_r = mem_read(mem_adr);
                end
                mem_ack = 1'b1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    task automatic run_access(input string name, input logic we, input word_t adr,
                              input sel_t sel, input word_t wdata,
                              output word_t rdata, output int cycles);
        cpu_cyc = 1'b1;
        cpu_stb = 1'b1;
        cpu_we = we;
        cpu_adr = adr;
        cpu_sel = sel;
        cpu_dat_w = wdata;
        wait_ack(name, cycles);
        rdata = cpu_dat_r;
        // strobe stays up through the edge that samples the ack
        @(posedge CLK);
        #1;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we = 1'b0;
    endtask

    task automatic run_flush(input string name);
        flush = 1'b1;
        @(posedge CLK);
        #1;
        flush = 1'b0;
        wait_flush_done(name);
        @(posedge CLK);
        #1;
    endtask

    task automatic check_reset_state();
        if (cpu_ack || mem_cyc || mem_stb || flush_done) begin
            $display("a handshake or bus output is high after reset");
            stop_with_failure();
        end
        check_count("reset", '0, misses);
    endtask

    initial begin : run_vectors
        int              fd;
        int              code;
        int              cycles;
        int              n_vectors;
        logic            reading;
        logic [8*32-1:0] name_tok;
        logic [8*8-1:0]  op_tok;
        logic [8*160-1:0] skip_buf;
        string           name;
        word_t           adr;
        word_t           wdata;
        word_t           exp_rdata;
        word_t           rdata;
        sel_t            sel;
        count_t          exp_misses;
        count_t          prev_misses;

        nRST = 1'b0;
        flush = 1'b0;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we = 1'b0;
        cpu_adr = '0;
        cpu_sel = '0;
        cpu_dat_w = '0;
        mem_ack = 1'b0;
        mem_dat_r = '0;
        seed = 32'h74b07edd;
        in_wait = 1'b0;
        wait_left = 0;
        n_vectors = 0;
        prev_misses = '0;

        repeat (16) @(posedge CLK);
        #1;
        nRST = 1'b1;
        check_reset_state();

        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the vector file %s", VECTOR_FILE);
            stop_with_failure();
        end
        reading = 1'b1;
        while (reading) begin
            code = $fscanf(fd, "%s", name_tok);
            if (code != 1) begin
                reading = 1'b0;
            end else if (name_tok == "#") begin
                code = $fgets(skip_buf, fd);
            end else begin
                code = $fscanf(fd, "%s %h %h %h %h %d", op_tok, adr, sel, wdata,
                               exp_rdata, exp_misses);
                name = $sformatf("%0s", name_tok);
                if (code != 6) begin
                    $display("%s: malformed vector line", name);
                    stop_with_failure();
                end
                if (op_tok == "flush") begin
                    run_flush(name);
                end else if (op_tok == "read" || op_tok == "write") begin
                    run_access(name, op_tok == "write", adr, sel, wdata, rdata, cycles);
                    if (op_tok == "read") begin
                        check_word(name, exp_rdata, rdata);
                    end
                    // cacheable with no new miss means a hit, acked one cycle later
                    if (adr < NONCACHE_BASE && exp_misses == prev_misses) begin
                        check_count({name, " latency"}, 1, cycles);
                    end
                end else begin
                    $display("%s: unknown operation in vector file", name);
                    stop_with_failure();
                end
                check_count(name, exp_misses, misses);
                prev_misses = exp_misses;
                n_vectors++;
                @(posedge CLK);
                #1;
            end
        end
        $fclose(fd);

        if (n_vectors == 0) begin
            $display("no vectors were read from %s", VECTOR_FILE);
            stop_with_failure();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
